// ==== list.f ====
source/sifh_geometry_pkg.sv
source/sifh_types_pkg.sv
source/sifh_sequencer.sv
source/sifh_bin_accumulator.sv
source/sifh_peak_search.sv
source/sifh_result_port.sv
source/sifh_top.sv
verification/sifh_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and judges the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -sv --top-module sifh_tb -f list.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vsifh_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

// ==== source/sifh_bin_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module sifh_bin_accumulator
    import sifh_geometry_pkg::*;
#(
    parameter int unsigned NB       = NB_DEFAULT,
    parameter int unsigned PIXELS   = PIXELS_DEFAULT,
    parameter int unsigned PEAK_W   = PEAK_W_DEFAULT,
    localparam int unsigned PW      = cnt_width(PIXELS)
) (
    input  wire                 clk,
    input  wire                 res,
    input  wire                 acc_valid,
    input  wire [NB-1:0]        acc_bin,
    input  wire [PW-1:0]        acc_pixel,
    input  wire                 rd_en,
    input  wire [PW-1:0]        rd_pixel,
    input  wire [NB-1:0]        rd_bin,
    output logic [PEAK_W-1:0]   rd_count,
    output logic                clear_done
);

    localparam int unsigned BINS  = 2 ** NB;
    localparam int unsigned DEPTH = PIXELS * BINS;
    localparam int unsigned AW    = PW + NB;

    logic [PEAK_W-1:0] ram [DEPTH];
    logic [AW-1:0]     clr_addr;
    logic              clearing;
    logic [AW-1:0]     acc_addr;
    logic [AW-1:0]     rd_addr;
    logic              s1_valid;
    logic [AW-1:0]     s1_addr;
    logic [PEAK_W-1:0] s1_count;
    logic              lw_valid;
    logic [AW-1:0]     lw_addr;
    logic [PEAK_W-1:0] lw_count;
    logic [PEAK_W-1:0] base;
    logic [PEAK_W-1:0] bumped;

    assign clearing = !clear_done;
    assign acc_addr = {acc_pixel, acc_bin}; // pixel * BINS + bin
    assign rd_addr  = {rd_pixel, rd_bin};

    // the RAM word read for s1 misses a write made on the same edge, take it from lw
    assign base   = (lw_valid && lw_addr == s1_addr) ? lw_count : s1_count;
    assign bumped = (&base) ? base : base + 1'b1;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clr_addr   <= '0;
            clear_done <= 1'b0;
        end else if (clearing) begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_addr == AW'(DEPTH - 1)) begin
                clear_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_valid <= 1'b0;
            lw_valid <= 1'b0;
        end else begin
            s1_valid <= acc_valid;
            lw_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_addr  <= acc_addr;
        s1_count <= ram[acc_addr];
        lw_addr  <= s1_addr;
        lw_count <= bumped;
        if (rd_en) begin
            rd_count <= ram[rd_addr];
        end
    end

    // one write port, shared by the sweep, the increment and the read-and-clear
    always_ff @(posedge clk) begin
        if (clearing) begin
            ram[clr_addr] <= '0;
        end else if (s1_valid) begin
            ram[s1_addr] <= bumped;
        end else if (rd_en) begin
            ram[rd_addr] <= '0;
        end
    end

    a_no_acc_while_clearing: assert property (@(posedge clk) disable iff (!res)
        acc_valid |-> clear_done);

    // the peak search waits for the last increment, or a clear would be lost
    a_no_clear_collision: assert property (@(posedge clk) disable iff (!res)
        rd_en |-> !s1_valid);

endmodule

`default_nettype wire

// ==== source/sifh_geometry_pkg.sv ====
`default_nettype none

package sifh_geometry_pkg;

    // sample word as delivered by the TDC
    localparam int unsigned NP_DEFAULT = 16;

    // upper sample bits that pick the bin, 2**NB bins per pixel
    localparam int unsigned NB_DEFAULT = 5;

    localparam int unsigned PIXELS_DEFAULT = 8; // pixels sharing one histogram RAM

    localparam int unsigned DATA_NUM_DEFAULT = 2; // samples per pixel before moving on

    localparam int unsigned ACQ_NUM_DEFAULT = 4; // full pixel sweeps per frame

    localparam int unsigned PEAK_W_DEFAULT = 4; // bin counter width, saturates at all ones

    localparam int unsigned CREDITS_DEFAULT = 2; // records the consumer can take up front

    // width of a counter or index that runs over n values
    function automatic int unsigned cnt_width(input int unsigned n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

endpackage

`default_nettype wire

// ==== source/sifh_peak_search.sv ====
`timescale 1ns/1ps
`default_nettype none

module sifh_peak_search
    import sifh_geometry_pkg::*;
    import sifh_types_pkg::*;
#(
    parameter int unsigned NB       = NB_DEFAULT,
    parameter int unsigned PIXELS   = PIXELS_DEFAULT,
    parameter int unsigned PEAK_W   = PEAK_W_DEFAULT,
    localparam int unsigned PW      = cnt_width(PIXELS)
) (
    input  wire                 clk,
    input  wire                 res,
    input  acq_phase_t          phase,
    input  wire [PEAK_W-1:0]    rd_count,
    input  wire                 rec_stall,
    output logic                rd_en,
    output logic [PW-1:0]       rd_pixel,
    output logic [NB-1:0]       rd_bin,
    output logic                rec_valid,
    output logic [PW-1:0]       rec_pixel,
    output logic [NB-1:0]       rec_bin,
    output logic [PEAK_W-1:0]   rec_count,
    output logic                search_done
);

    logic              armed;
    logic              starting;
    logic              reading;
    logic [NB-1:0]     bin_q;
    logic [PW-1:0]     pix_q;
    logic              d_valid;
    logic [NB-1:0]     d_bin;
    logic [PW-1:0]     d_pix;
    logic [PEAK_W-1:0] max_count;
    logic [NB-1:0]     max_bin;
    logic              take;
    logic [PEAK_W-1:0] best_count;
    logic [NB-1:0]     best_bin;

    assign rd_en    = reading && !rec_stall;
    assign rd_pixel = pix_q;
    assign rd_bin   = bin_q;

    // bin 0 restarts the maximum, strict compare keeps the lowest bin on a tie
    assign take       = (d_bin == '0) || (rd_count > max_count);
    assign best_count = take ? rd_count : max_count;
    assign best_bin   = take ? d_bin : max_bin;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            armed       <= 1'b1;
            starting    <= 1'b0;
            reading     <= 1'b0;
            bin_q       <= '0;
            pix_q       <= '0;
            d_valid     <= 1'b0;
            rec_valid   <= 1'b0;
            search_done <= 1'b0;
        end else begin
            starting <= 1'b0;
            if (phase != PHASE_SEARCH) begin
                armed <= 1'b1;
            end else if (armed) begin
                armed    <= 1'b0;
                starting <= 1'b1; // one spare cycle so the last increment lands first
            end
            if (starting) begin
                reading <= 1'b1;
            end
            if (rd_en) begin
                bin_q <= bin_q + 1'b1;
                if (&bin_q) begin
                    pix_q <= (pix_q == PW'(PIXELS - 1)) ? '0 : pix_q + 1'b1;
                    if (pix_q == PW'(PIXELS - 1)) begin
                        reading <= 1'b0;
                    end
                end
            end
            d_valid     <= rd_en;
            rec_valid   <= d_valid && (&d_bin);
            search_done <= d_valid && (&d_bin) && (d_pix == PW'(PIXELS - 1));
        end
    end

    always_ff @(posedge clk) begin
        d_bin <= bin_q;
        d_pix <= pix_q;
        if (d_valid) begin
            max_count <= best_count;
            max_bin   <= best_bin;
        end
        if (d_valid && (&d_bin)) begin
            rec_pixel <= d_pix;
            rec_bin   <= best_bin;
            rec_count <= best_count;
        end
    end

endmodule

`default_nettype wire

// ==== source/sifh_result_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module sifh_result_port
    import sifh_geometry_pkg::*;
    import sifh_types_pkg::*;
#(
    parameter int unsigned NB       = NB_DEFAULT,
    parameter int unsigned PIXELS   = PIXELS_DEFAULT,
    parameter int unsigned PEAK_W   = PEAK_W_DEFAULT,
    parameter int unsigned CREDITS  = CREDITS_DEFAULT,
    localparam int unsigned PW      = cnt_width(PIXELS)
) (
    input  wire                 clk,
    input  wire                 res,
    input  acq_phase_t          phase,
    input  wire                 rec_valid,
    input  wire [PW-1:0]        rec_pixel,
    input  wire [NB-1:0]        rec_bin,
    input  wire [PEAK_W-1:0]    rec_count,
    input  wire                 credit_return,
    output logic                rec_stall,
    output logic                peak_valid,
    output logic [PW-1:0]       peak_pixel,
    output logic [NB-1:0]       peak_bin,
    output logic [PEAK_W-1:0]   peak_count,
    output logic                drain_done
);

    localparam int unsigned CW = cnt_width(CREDITS + 1);

    logic              full;
    logic [PW-1:0]     buf_pixel;
    logic [NB-1:0]     buf_bin;
    logic [PEAK_W-1:0] buf_count;
    logic [CW-1:0]     credit_cnt;
    logic [PW-1:0]     sent_cnt;
    logic              send;

    assign send      = full && (credit_cnt != '0);
    assign rec_stall = full && (credit_cnt == '0); // a full buffer with credit empties this cycle

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            full       <= 1'b0;
            credit_cnt <= CW'(CREDITS);
            sent_cnt   <= '0;
            peak_valid <= 1'b0;
            drain_done <= 1'b0;
        end else begin
            if (rec_valid) begin
                full <= 1'b1;
            end else if (send) begin
                full <= 1'b0;
            end
            case ({send, credit_return})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
            if (phase == PHASE_IDLE) begin
                sent_cnt <= '0;
            end else if (send) begin
                sent_cnt <= (sent_cnt == PW'(PIXELS - 1)) ? '0 : sent_cnt + 1'b1;
            end
            peak_valid <= send;
            drain_done <= send && (sent_cnt == PW'(PIXELS - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (rec_valid) begin
            buf_pixel <= rec_pixel;
            buf_bin   <= rec_bin;
            buf_count <= rec_count;
        end
        if (send) begin
            peak_pixel <= buf_pixel;
            peak_bin   <= buf_bin;
            peak_count <= buf_count;
        end
    end

    a_send_needs_credit: assert property (@(posedge clk) disable iff (!res)
        peak_valid |-> $past(credit_cnt) != '0);

    // a consumer returning more than it was given would overrun the counter
    a_credit_bound: assert property (@(posedge clk) disable iff (!res)
        credit_cnt <= CW'(CREDITS));

endmodule

`default_nettype wire

// ==== source/sifh_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sifh_sequencer
    import sifh_geometry_pkg::*;
    import sifh_types_pkg::*;
#(
    parameter int unsigned NP       = NP_DEFAULT,
    parameter int unsigned NB       = NB_DEFAULT,
    parameter int unsigned PIXELS   = PIXELS_DEFAULT,
    parameter int unsigned DATA_NUM = DATA_NUM_DEFAULT,
    parameter int unsigned ACQ_NUM  = ACQ_NUM_DEFAULT,
    localparam int unsigned PW      = cnt_width(PIXELS)
) (
    input  wire             clk,
    input  wire             res,
    input  wire             wr_en,
    input  wire             sample_valid,
    input  wire [NP-1:0]    sample_data,
    input  wire             clear_done,
    input  wire             search_done,
    input  wire             drain_done,
    output logic            sample_ready,
    output logic            acc_valid,
    output logic [NB-1:0]   acc_bin,
    output logic [PW-1:0]   acc_pixel,
    output acq_phase_t      phase
);

    localparam int unsigned DW = cnt_width(DATA_NUM);
    localparam int unsigned QW = cnt_width(ACQ_NUM);

    logic [DW-1:0] data_cnt;
    logic [PW-1:0] pixel_cnt;
    logic [QW-1:0] acq_cnt;
    logic          accept;
    logic          data_last;
    logic          pixel_last;
    logic          acq_last;
    logic          frame_last;

    assign sample_ready = (phase == PHASE_BUILD);
    assign accept       = sample_valid && sample_ready;
    assign data_last    = (data_cnt == DW'(DATA_NUM - 1));
    assign pixel_last   = (pixel_cnt == PW'(PIXELS - 1));
    assign acq_last     = (acq_cnt == QW'(ACQ_NUM - 1));
    assign frame_last   = accept && data_last && pixel_last && acq_last;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            phase <= PHASE_IDLE;
        end else begin
            case (phase)
                PHASE_IDLE:   if (wr_en && clear_done) phase <= PHASE_BUILD; // RAM must be swept
                PHASE_BUILD:  if (frame_last) phase <= PHASE_SEARCH;
                PHASE_SEARCH: if (search_done) phase <= PHASE_DRAIN;
                PHASE_DRAIN:  if (drain_done) phase <= PHASE_IDLE;
                default:      phase <= PHASE_IDLE;
            endcase
        end
    end

    // all three counters wrap to zero on the last sample of the frame
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            data_cnt  <= '0;
            pixel_cnt <= '0;
            acq_cnt   <= '0;
        end else if (accept) begin
            if (data_last) begin
                data_cnt <= '0;
                if (pixel_last) begin
                    pixel_cnt <= '0;
                    acq_cnt   <= acq_last ? '0 : acq_cnt + 1'b1;
                end else begin
                    pixel_cnt <= pixel_cnt + 1'b1;
                end
            end else begin
                data_cnt <= data_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            acc_bin   <= sample_data[NP-1 -: NB]; // lower timing bits are dropped
            acc_pixel <= pixel_cnt;
        end
    end

    a_sample_in_build: assert property (@(posedge clk) disable iff (!res)
        sample_valid |-> phase == PHASE_BUILD);

endmodule

`default_nettype wire

// ==== source/sifh_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sifh_top
    import sifh_geometry_pkg::*;
    import sifh_types_pkg::*;
#(
    parameter int unsigned NP       = NP_DEFAULT,
    parameter int unsigned NB       = NB_DEFAULT,
    parameter int unsigned PIXELS   = PIXELS_DEFAULT,
    parameter int unsigned DATA_NUM = DATA_NUM_DEFAULT,
    parameter int unsigned ACQ_NUM  = ACQ_NUM_DEFAULT,
    parameter int unsigned PEAK_W   = PEAK_W_DEFAULT,
    parameter int unsigned CREDITS  = CREDITS_DEFAULT,
    localparam int unsigned PW      = cnt_width(PIXELS)
) (
    input  wire                 clk,
    input  wire                 res,
    input  wire                 wr_en,
    input  wire                 sample_valid,
    input  wire [NP-1:0]        sample_data,
    input  wire                 credit_return,
    output logic                sample_ready,
    output acq_phase_t          phase,
    output logic                peak_valid,
    output logic [PW-1:0]       peak_pixel,
    output logic [NB-1:0]       peak_bin,
    output logic [PEAK_W-1:0]   peak_count
);

    logic              acc_valid;
    logic [NB-1:0]     acc_bin;
    logic [PW-1:0]     acc_pixel;
    logic              clear_done;
    logic              search_done;
    logic              drain_done;
    logic              rd_en;
    logic [PW-1:0]     rd_pixel;
    logic [NB-1:0]     rd_bin;
    logic [PEAK_W-1:0] rd_count;
    logic              rec_valid;
    logic [PW-1:0]     rec_pixel;
    logic [NB-1:0]     rec_bin;
    logic [PEAK_W-1:0] rec_count;
    logic              rec_stall;

    sifh_sequencer #(
        .NP(NP), .NB(NB), .PIXELS(PIXELS), .DATA_NUM(DATA_NUM), .ACQ_NUM(ACQ_NUM)
    ) seq0 (
        .clk, .res, .wr_en, .sample_valid, .sample_data,
        .clear_done, .search_done, .drain_done,
        .sample_ready, .acc_valid, .acc_bin, .acc_pixel, .phase
    );

    sifh_bin_accumulator #(.NB(NB), .PIXELS(PIXELS), .PEAK_W(PEAK_W)) acc0 (
        .clk, .res, .acc_valid, .acc_bin, .acc_pixel,
        .rd_en, .rd_pixel, .rd_bin, .rd_count, .clear_done
    );

    sifh_peak_search #(.NB(NB), .PIXELS(PIXELS), .PEAK_W(PEAK_W)) peak0 (
        .clk, .res, .phase, .rd_count, .rec_stall,
        .rd_en, .rd_pixel, .rd_bin,
        .rec_valid, .rec_pixel, .rec_bin, .rec_count, .search_done
    );

    sifh_result_port #(
        .NB(NB), .PIXELS(PIXELS), .PEAK_W(PEAK_W), .CREDITS(CREDITS)
    ) port0 (
        .clk, .res, .phase, .rec_valid, .rec_pixel, .rec_bin, .rec_count,
        .credit_return, .rec_stall,
        .peak_valid, .peak_pixel, .peak_bin, .peak_count, .drain_done
    );

endmodule

`default_nettype wire

// ==== source/sifh_types_pkg.sv ====
`default_nettype none

package sifh_types_pkg;

    // frame phases, gray coded so each step flips one bit
    typedef enum logic [1:0] {
        PHASE_IDLE   = 2'b00, // waiting for wr_en
        PHASE_BUILD  = 2'b01, // samples accepted and binned
        PHASE_SEARCH = 2'b11, // histograms scanned for their peaks
        PHASE_DRAIN  = 2'b10  // last records leaving under credit
    } acq_phase_t;

endpackage

`default_nettype wire

// ==== verification/sifh_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sifh_tb
    import sifh_types_pkg::*;
();

    localparam int NP          = 8;
    localparam int NB          = 3;
    localparam int PIXELS      = 4;
    localparam int DATA_NUM    = 2;
    localparam int ACQ_NUM     = 3;
    localparam int PEAK_W      = 2;
    localparam int CREDITS     = 2;
    localparam int PW          = $clog2(PIXELS);
    localparam int BINS        = 2 ** NB;
    localparam int SAMPLES     = PIXELS * DATA_NUM * ACQ_NUM;
    localparam int WORDS       = SAMPLES + PIXELS; // samples then expected records
    localparam int FRAMES      = 2;
    localparam int HOLD_CYCLES = 40;
    localparam int MAX_DELAY   = 7;
    localparam logic [31:0] SEED = 32'h6d4fa777;
    // sweep, intake, start-up, scan, one credit round trip per record and the hold
    localparam int FRAME_WORST = BINS * PIXELS + SAMPLES + 3 + BINS * PIXELS
                                 + PIXELS * (MAX_DELAY + 4) + HOLD_CYCLES;
    localparam int TIMEOUT_CYCLES = 2 * FRAME_WORST * FRAMES;

    logic              clk;
    logic              res;
    logic              wr_en;
    logic              sample_valid;
    logic [NP-1:0]     sample_data;
    logic              credit_return;
    logic              sample_ready;
    acq_phase_t        phase;
    logic              peak_valid;
    logic [PW-1:0]     peak_pixel;
    logic [NB-1:0]     peak_bin;
    logic [PEAK_W-1:0] peak_count;

    logic [11:0] testdata [FRAMES * WORDS];
    int          cycle_cnt;
    int          reset_cycle;
    int          error_cnt = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cur_frame = 0;
    int          rec_seen = 0;
    int          sent_total = 0;
    int          returned_total = 0;
    logic        hold_credits = 1'b0;

    sifh_top #(
        .NP(NP), .NB(NB), .PIXELS(PIXELS), .DATA_NUM(DATA_NUM), .ACQ_NUM(ACQ_NUM),
        .PEAK_W(PEAK_W), .CREDITS(CREDITS)
    ) dut0 (
        .clk, .res, .wr_en, .sample_valid, .sample_data, .credit_return,
        .sample_ready, .phase, .peak_valid, .peak_pixel, .peak_bin, .peak_count
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic note_failure(input string msg);
        $display("Fail %0t: %s", $time, msg);
        error_cnt++;
    endtask

    task automatic check_flag(input logic got, input logic want, input string what);
        if (got !== want) begin
            $display("Fail %0t: %s is %b, expected %b", $time, what, got, want);
            error_cnt++;
        end
    endtask

    task automatic check_phase(input acq_phase_t got, input acq_phase_t want, input string what);
        if (got !== want) begin
            $display("Fail %0t: phase %s at %s, expected %s", $time, got.name(), what,
                     want.name());
            error_cnt++;
        end
    endtask

    task automatic check_record(input logic [PW-1:0] got_pixel, input logic [NB-1:0] got_bin,
                                input logic [PEAK_W-1:0] got_count,
                                input logic [PW-1:0] want_pixel, input logic [NB-1:0] want_bin,
                                input logic [PEAK_W-1:0] want_count);
        if (got_pixel !== want_pixel || got_bin !== want_bin || got_count !== want_count) begin
            $display("Fail %0t: record pixel %0d bin %0d count %0d, expected %0d %0d %0d",
                     $time, got_pixel, got_bin, got_count, want_pixel, want_bin, want_count);
            error_cnt++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (error_cnt == errs_before) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     error_cnt - errs_before);
        end
    endtask

    // wr_en stays high until the sequencer opens the sample input
    task automatic start_frame(input int frame);
        int waited;
        wr_en = 1'b1;
        next_cycle();
        waited = 1;
        while (!sample_ready) begin
            next_cycle();
            waited++;
        end
        wr_en = 1'b0;
        if (frame == 0 && cycle_cnt - reset_cycle < BINS * PIXELS) begin
            note_failure("sample_ready rose before the RAM clearing sweep could finish");
        end
        if (frame > 0 && waited != 1) begin
            note_failure($sformatf("sample_ready came %0d cycles after wr_en, not 1", waited));
        end
    endtask

    task automatic run_frame(input int frame);
        cur_frame = frame;
        rec_seen = 0;
        check_phase(phase, PHASE_IDLE, "frame start");
        start_frame(frame);
        check_phase(phase, PHASE_BUILD, "sample intake");
        if (frame == 1) begin
            hold_credits = 1'b1;
        end
        for (int i = 0; i < SAMPLES; i++) begin
            check_flag(sample_ready, 1'b1, "sample_ready during intake");
            sample_valid = 1'b1;
            sample_data  = testdata[frame * WORDS + i][NP-1:0];
            next_cycle();
        end
        sample_valid = 1'b0;
        check_phase(phase, PHASE_SEARCH, "last sample");
        check_flag(sample_ready, 1'b0, "sample_ready after the last sample");
        if (frame == 1) begin
            while (rec_seen < CREDITS) begin
                next_cycle();
            end
            repeat (HOLD_CYCLES) next_cycle();
            if (rec_seen != CREDITS) begin
                note_failure("records kept coming while credits were held back");
            end
            check_phase(phase, PHASE_SEARCH, "credit hold");
            hold_credits = 1'b0;
        end
        while (phase == PHASE_SEARCH) begin
            next_cycle();
        end
        check_phase(phase, PHASE_DRAIN, "end of search");
        while (phase == PHASE_DRAIN) begin
            next_cycle();
        end
        check_phase(phase, PHASE_IDLE, "end of drain");
        if (rec_seen != PIXELS) begin
            note_failure($sformatf("frame ended with %0d records instead of %0d",
                                   rec_seen, PIXELS));
        end
        while (returned_total != sent_total) begin
            next_cycle();
        end
    endtask

    // records are compared in arrival order, so pixel order is checked too
    always @(negedge clk) begin
        logic [11:0] want;
        if (res && peak_valid) begin
            sent_total++;
            if (sent_total - returned_total > CREDITS) begin
                note_failure("a record was sent without an available credit");
            end
            if (rec_seen >= PIXELS) begin
                note_failure("more records than pixels in one frame");
            end else begin
                want = testdata[cur_frame * WORDS + SAMPLES + rec_seen];
                check_record(peak_pixel, peak_bin, peak_count, PW'(want[11:8]),
                             NB'(want[7:4]), PEAK_W'(want[3:0]));
            end
            rec_seen++;
        end
    end

    initial begin
        int          delay;
        logic [31:0] rng;
        credit_return = 1'b0;
        rng = xorshift32(SEED);
        delay = int'(rng[2:0]);
        forever begin
            next_cycle();
            credit_return = 1'b0;
            if (sent_total > returned_total && !hold_credits) begin
                if (delay == 0) begin
                    credit_return = 1'b1; // one credit per pulse
                    returned_total++;
                    rng = xorshift32(rng);
                    delay = int'(rng[2:0]);
                end else begin
                    delay--;
                end
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("simulation timed out after %0d cycles without finishing the tests", cycle_cnt);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int    errs;
        string name;
        res = 1'b0;
        wr_en = 1'b0;
        sample_valid = 1'b0;
        sample_data = '0;
        $readmemh("verification/sifh_testdata.txt", testdata);
        repeat (4) @(posedge clk);
        #2;
        res = 1'b1;
        reset_cycle = cycle_cnt;

        errs = error_cnt;
        check_phase(phase, PHASE_IDLE, "reset");
        check_flag(peak_valid, 1'b0, "peak_valid after reset");
        repeat (3) begin
            check_flag(sample_ready, 1'b0, "sample_ready before wr_en");
            next_cycle();
        end
        finish_test("reset state", errs);

        for (int f = 0; f < FRAMES; f++) begin
            errs = error_cnt;
            if (f == 0) begin
                name = "frame 1 histogram peaks and saturation";
            end else begin
                name = "frame 2 clearing and credit hold";
            end
            run_frame(f);
            finish_test(name, errs);
        end

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_cnt);
        if (error_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/sifh_testdata.txt ====
// sample words hold the 8 bit sample_data, the bin is its upper 3 bits
// record words hold pixel, bin and count, one hex digit each
// frame 1 samples, sweep by sweep, two per pixel
0a3 // sweep 0, pixel 0
0be
06c // pixel 1
0d1
007 // pixel 2
0f2
029 // pixel 3
095
0a0 // sweep 1
0b7
0c4
07a
0e9
03c
011
0dd
0af // sweep 2
0a8
02e
01b
058
0ff
084
046
// frame 1 records, pixel 0 saturates in bin 5, pixel 1 ties bins 3 and 6
053
132
273
342
// frame 2 samples on other bins, leftover counts would win these
0c1 // sweep 0
0da
0e3
0f8
0cc
00e
04b
0b0
012 // sweep 1
05d
0a6
099
0d4
0b9
0aa
0e1
067 // sweep 2
0f5
01f
052
033
071
00c
03a
// frame 2 records
062
172
262
352
